/* Makefile */
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module bridge_tb \
		-Mdir $(OBJ_DIR) -o bridge_tb

run: compile
	./$(OBJ_DIR)/bridge_tb | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* src/axil_reg_port.sv */
`timescale 1ns/10ps
`include "bridge_params.svh"

module axil_reg_port (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  bridge_pkg::axil_req_t       axil_req,
    output bridge_pkg::axil_rsp_t       axil_rsp,
    output bridge_pkg::reg_access_t     access,
    input  logic [`AXIL_DW-1:0]         ctrl_rdata,
    input  logic [`AXIL_DW-1:0]         msi_rdata
);

    localparam int IDX_W = `AXIL_AW - 2;

    logic                   wr_lock;    // write response outstanding
    logic                   wr_ready;   // drives awready and wready
    logic                   bvalid;
    logic                   arready;
    logic                   rvalid;
    logic [IDX_W-1:0]       rd_index_q;
    logic [`AXIL_DW-1:0]    rdata_q;
    logic [`AXIL_DW-1:0]    rd_word;
    logic                   wr_fire;
    logic                   ar_fire;
    logic                   rd_fire;

    //////////////////////////////
    // write channel
    assign wr_fire = wr_ready & axil_req.awvalid & axil_req.wvalid;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_lock  <= 1'b0;
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
        end else begin
            wr_ready <= axil_req.awvalid & axil_req.wvalid & ~wr_lock;   // one cycle pulse
            if (axil_req.awvalid && axil_req.wvalid && !wr_lock) begin
                wr_lock <= 1'b1;
            end else if (bvalid && axil_req.bready) begin
                wr_lock <= 1'b0;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // read channel
    assign ar_fire = arready & axil_req.arvalid;
    assign rd_fire = rvalid & axil_req.rready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= ~arready & ~rvalid & axil_req.arvalid;
            if (ar_fire) begin
                rvalid <= 1'b1;
            end else if (rd_fire) begin
                rvalid <= 1'b0;
            end
        end
    end

    // index held from arvalid through the ar handshake
    always_ff @(posedge aclk) begin
        if (axil_req.arvalid && !rvalid) begin
            rd_index_q <= axil_req.araddr[`AXIL_AW-1:2];
        end
        if (ar_fire) begin
            rdata_q <= rd_word;
        end
    end

    always_comb begin
        if (rd_index_q <= IDX_W'(`REG_DB_TXINFO)) begin
            rd_word = ctrl_rdata;
        end else if (rd_index_q <= IDX_W'(`REG_MSI_INFO_LAST)) begin
            rd_word = msi_rdata;
        end else begin
            rd_word = '0;   // unmapped
        end
    end

    //////////////////////////////
    // outputs
    always_comb begin
        axil_rsp.awready = wr_ready;
        axil_rsp.wready  = wr_ready;
        axil_rsp.bresp   = 2'b00;   // always okay
        axil_rsp.bvalid  = bvalid;
        axil_rsp.arready = arready;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = 2'b00;
        axil_rsp.rvalid  = rvalid;

        access.wr       = wr_fire;
        access.rd_done  = rd_fire;
        access.wr_index = axil_req.awaddr[`AXIL_AW-1:2];
        access.rd_index = rd_index_q;
        access.wdata    = axil_req.wdata;
        access.wstrb    = axil_req.wstrb;
    end

    // responses hold under back-pressure
    assert property (@(posedge aclk) disable iff (!aresetn)
        bvalid && !axil_req.bready |=> bvalid)
        else $error("bvalid fell before bready");

    assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid && !axil_req.rready |=> rvalid)
        else $error("rvalid fell before rready");

endmodule

/* src/bridge_params.svh */
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// bus and irq widths
`define AXIL_DW     32
`define AXIL_AW     7
`define USR_IRQ_DW  16

`define IDENT_VALUE 32'h10370918

// word indices of the register map
`define REG_IDENT           0
`define REG_SRIO_CSR        1
`define REG_SRIO_MODE       2
`define REG_SW_SIZE         3
`define REG_SW_DST          4
`define REG_SW_SRC          5
`define REG_DB_TXINFO       6
`define REG_MSI_CSR         7
`define REG_MSI_INFO_FIRST  8
`define REG_MSI_INFO_LAST   23

// field layout
`define SW_SIZE_W   27
`define ERR_LSB     16   // sticky error bits start here in both csr words

`endif

/* src/bridge_pkg.sv */
`include "bridge_params.svh"

package bridge_pkg;

    // driven by the bus master
    typedef struct packed {
        logic [`AXIL_AW-1:0]     awaddr;
        logic                    awvalid;
        logic [`AXIL_DW-1:0]     wdata;
        logic [`AXIL_DW/8-1:0]   wstrb;
        logic                    wvalid;
        logic                    bready;
        logic [`AXIL_AW-1:0]     araddr;
        logic                    arvalid;
        logic                    rready;
    } axil_req_t;

    // returned by the slave
    typedef struct packed {
        logic                    awready;
        logic                    wready;
        logic [1:0]              bresp;
        logic                    bvalid;
        logic                    arready;
        logic [`AXIL_DW-1:0]     rdata;
        logic [1:0]              rresp;
        logic                    rvalid;
    } axil_rsp_t;

    // one word-indexed register access
    typedef struct packed {
        logic                    wr;        // write strobe, handshake cycle
        logic                    rd_done;   // read completion strobe
        logic [`AXIL_AW-3:0]     wr_index;
        logic [`AXIL_AW-3:0]     rd_index;
        logic [`AXIL_DW-1:0]     wdata;
        logic [`AXIL_DW/8-1:0]   wstrb;
    } reg_access_t;

    // to the transmit engine
    typedef struct packed {
        logic                    db_start;  // held until db_done
        logic                    sw_start;  // held until sw_done
        logic                    sw_mode;
        logic [`SW_SIZE_W-1:0]   sw_size;
        logic [31:0]             sw_dst;
        logic [31:0]             sw_src;
        logic [15:0]             db_info_normal;
        logic [15:0]             db_info_sw;
    } tx_cmd_t;

    // from the transmit engine
    typedef struct packed {
        logic                    db_done;
        logic                    sw_done;
        logic                    sw_err_src_unalign;
        logic                    sw_err_dst_unalign;
    } tx_status_t;

    // from the receive engine
    typedef struct packed {
        logic                    db_irq;
        logic [15:0]             db_info;
        logic                    nw_err_cross;     // nwrite crosses 4k
        logic                    nw_err_unalign;
    } rx_event_t;

endpackage

/* src/msi_irq_ctrl.sv */
`timescale 1ns/10ps
`include "bridge_params.svh"

module msi_irq_ctrl (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  bridge_pkg::reg_access_t     access,
    output logic [`AXIL_DW-1:0]         rdata,
    input  logic                        db_nomsi,
    input  bridge_pkg::rx_event_t       rx_event,
    input  logic                        msi_irq_in,     // valid only while not busy
    input  logic [`AXIL_DW-1:0]         msi_info_in,
    output logic                        msi_irq_busy,
    output logic [`USR_IRQ_DW-1:0]      usr_irq_req
);

    localparam int IDX_W  = `AXIL_AW - 2;
    localparam int SLOTS  = `REG_MSI_INFO_LAST - `REG_MSI_INFO_FIRST + 1;
    localparam int SLOT_W = $clog2(SLOTS);

    logic [`USR_IRQ_DW-1:0]     pend;
    logic [`USR_IRQ_DW-1:0]     err;
    logic [`AXIL_DW-1:0]        info [SLOTS];

    logic [`AXIL_DW-1:0]        wmask;
    logic [IDX_W-1:0]           wr_off;
    logic [IDX_W-1:0]           rd_off;
    logic                       csr_wr;
    logic                       info_wr;
    logic                       lo_set;     // software set in byte 0
    logic                       hi_set;     // software set in byte 1
    logic [`USR_IRQ_DW-1:0]     set_req;
    logic [`USR_IRQ_DW-1:0]     rd_clr;
    logic [`USR_IRQ_DW-1:0]     err_clr;

    assign wmask  = {{8{access.wstrb[3]}}, {8{access.wstrb[2]}},
                     {8{access.wstrb[1]}}, {8{access.wstrb[0]}}};
    assign wr_off = access.wr_index - IDX_W'(`REG_MSI_INFO_FIRST);
    assign rd_off = access.rd_index - IDX_W'(`REG_MSI_INFO_FIRST);

    //////////////////////////////
    // event and software set requests
    always_comb begin
        csr_wr  = access.wr && (access.wr_index == `REG_MSI_CSR);
        info_wr = access.wr && (access.wr_index >= `REG_MSI_INFO_FIRST)
                            && (access.wr_index <= `REG_MSI_INFO_LAST);
        lo_set  = csr_wr && access.wstrb[0] && (|access.wdata[7:2]);
        hi_set  = csr_wr && access.wstrb[1] && (|access.wdata[15:8]);

        set_req    = '0;
        set_req[0] = rx_event.db_irq && !db_nomsi;  // doorbell to msi
        set_req[1] = msi_irq_in;
        if (lo_set) begin
            set_req[7:2] = access.wdata[7:2];
        end
        if (hi_set) begin
            set_req[15:8] = access.wdata[15:8];
        end

        err_clr = '0;
        if (csr_wr && !lo_set && access.wstrb[2]) begin
            err_clr[7:0] = access.wdata[`ERR_LSB +: 8];
        end
        if (csr_wr && !hi_set && access.wstrb[3]) begin
            err_clr[15:8] = access.wdata[`ERR_LSB + 8 +: 8];
        end

        // reading the info slot acknowledges the hardware irq
        rd_clr    = '0;
        rd_clr[0] = access.rd_done && (access.rd_index == `REG_MSI_INFO_FIRST);
        rd_clr[1] = access.rd_done && (access.rd_index == `REG_MSI_INFO_FIRST + 1);
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            pend <= '0;
            err  <= '0;
        end else begin
            pend <= (pend & ~rd_clr) | set_req;
            err  <= (err & ~err_clr) | (set_req & pend);    // set on a pending bit
        end
    end

    // hardware capture wins over a bus write to a slot
    always_ff @(posedge aclk) begin
        if (info_wr) begin
            info[wr_off[SLOT_W-1:0]] <= (info[wr_off[SLOT_W-1:0]] & ~wmask)
                                      | (access.wdata & wmask);
        end
        if (set_req[0] && !pend[0]) begin
            info[0] <= {{(`AXIL_DW - 16){1'b0}}, rx_event.db_info};
        end
        if (set_req[1] && !pend[1]) begin
            info[1] <= msi_info_in;
        end
    end

    //////////////////////////////
    // read mux and outputs
    always_comb begin
        rdata = '0;
        if (access.rd_index == `REG_MSI_CSR) begin
            rdata[`USR_IRQ_DW-1:0]          = pend;
            rdata[`ERR_LSB +: `USR_IRQ_DW]  = err;
        end else if ((access.rd_index >= `REG_MSI_INFO_FIRST)
                     && (access.rd_index <= `REG_MSI_INFO_LAST)) begin
            rdata = info[rd_off[SLOT_W-1:0]];
        end
    end

    assign msi_irq_busy = pend[1];
    assign usr_irq_req  = pend;

    assert property (@(posedge aclk) disable iff (!aresetn)
        msi_irq_busy |-> !msi_irq_in)
        else $error("msi_irq_in raised while msi_irq_busy");

endmodule

/* src/srio_ctrl_regs.sv */
`timescale 1ns/10ps
`include "bridge_params.svh"

module srio_ctrl_regs (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  bridge_pkg::reg_access_t     access,
    output logic [`AXIL_DW-1:0]         rdata,
    output bridge_pkg::tx_cmd_t         tx_cmd,
    input  bridge_pkg::tx_status_t      tx_status,
    input  bridge_pkg::rx_event_t       rx_event,
    output logic                        nw_mode,
    output logic                        db_nomsi
);

    localparam int ERR_N = 6;   // csr bits 16..21

    logic [1:0]                 busy;       // 0 doorbell, 1 streaming write
    logic [ERR_N-1:0]           err;
    logic [2:0]                 mode;
    logic [`SW_SIZE_W-1:0]      sw_size;
    logic [`AXIL_DW-1:0]        sw_dst;
    logic [`AXIL_DW-1:0]        sw_src;
    logic [`AXIL_DW-1:0]        db_txinfo;

    logic [`AXIL_DW-1:0]        wmask;
    logic                       csr_wr;
    logic                       start_wr;
    logic [1:0]                 done;
    logic [1:0]                 busy_set;
    logic [1:0]                 busy_err;
    logic [ERR_N-1:0]           err_set;
    logic [ERR_N-1:0]           err_clr;

    assign wmask = {{8{access.wstrb[3]}}, {8{access.wstrb[2]}},
                    {8{access.wstrb[1]}}, {8{access.wstrb[0]}}};
    assign done  = {tx_status.sw_done, tx_status.db_done};

    //////////////////////////////
    // start, busy and sticky errors
    always_comb begin
        csr_wr   = access.wr && (access.wr_index == `REG_SRIO_CSR);
        start_wr = csr_wr && access.wstrb[0] && (|access.wdata[1:0]);
        busy_set = start_wr ? (access.wdata[1:0] & ~busy) : 2'b00;
        busy_err = start_wr ? (access.wdata[1:0] & busy) : 2'b00;   // start while busy
        err_clr  = '0;
        if (csr_wr && !start_wr && access.wstrb[2]) begin
            err_clr = access.wdata[`ERR_LSB +: ERR_N];
        end
        err_set  = {tx_status.sw_err_dst_unalign, tx_status.sw_err_src_unalign,
                    rx_event.nw_err_unalign, rx_event.nw_err_cross, busy_err};
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            busy      <= '0;
            err       <= '0;
            mode      <= '0;
            sw_size   <= '0;
            sw_dst    <= '0;
            sw_src    <= '0;
            db_txinfo <= '0;
        end else begin
            busy <= (busy & ~done) | busy_set;
            err  <= (err & ~err_clr) | err_set;     // set wins over clear
            if (access.wr) begin
                case (access.wr_index)
                    `REG_SRIO_MODE: begin
                        if (access.wstrb[0]) begin
                            mode <= access.wdata[2:0];
                        end
                    end
                    `REG_SW_SIZE: sw_size <= (sw_size & ~wmask[`SW_SIZE_W-1:0])
                                           | (access.wdata[`SW_SIZE_W-1:0]
                                              & wmask[`SW_SIZE_W-1:0]);
                    `REG_SW_DST: sw_dst <= (sw_dst & ~wmask) | (access.wdata & wmask);
                    `REG_SW_SRC: sw_src <= (sw_src & ~wmask) | (access.wdata & wmask);
                    `REG_DB_TXINFO: db_txinfo <= (db_txinfo & ~wmask) | (access.wdata & wmask);
                    default: begin
                    end
                endcase
            end
        end
    end

    //////////////////////////////
    // read mux
    always_comb begin
        rdata = '0;
        case (access.rd_index)
            `REG_IDENT: rdata = `IDENT_VALUE;
            `REG_SRIO_CSR: begin
                rdata[1:0]                = busy;
                rdata[`ERR_LSB +: ERR_N]  = err;
            end
            `REG_SRIO_MODE: rdata[2:0] = mode;
            `REG_SW_SIZE:   rdata[`SW_SIZE_W-1:0] = sw_size;
            `REG_SW_DST:    rdata = sw_dst;
            `REG_SW_SRC:    rdata = sw_src;
            `REG_DB_TXINFO: rdata = db_txinfo;
            default:        rdata = '0;
        endcase
    end

    // engine side
    always_comb begin
        tx_cmd.db_start       = busy[0];
        tx_cmd.sw_start       = busy[1];
        tx_cmd.sw_mode        = mode[1];
        tx_cmd.sw_size        = sw_size;
        tx_cmd.sw_dst         = sw_dst;
        tx_cmd.sw_src         = sw_src;
        tx_cmd.db_info_normal = db_txinfo[15:0];
        tx_cmd.db_info_sw     = db_txinfo[31:16];
    end

    assign db_nomsi = mode[0];
    assign nw_mode  = mode[2];

    // busy only drops after the engine reports done
    genvar g;
    for (g = 0; g < 2; g++) begin : g_busy_chk
        assert property (@(posedge aclk) disable iff (!aresetn)
            busy[g] && !done[g] |=> busy[g])
            else $error("busy bit %0d fell without done", g);
    end

endmodule

/* src/srio_pcie_bridge.sv */
`timescale 1ns/10ps
`include "bridge_params.svh"

module srio_pcie_bridge (
    input  logic                        aclk,
    input  logic                        aresetn,

    // software access
    input  bridge_pkg::axil_req_t       axil_req,
    output bridge_pkg::axil_rsp_t       axil_rsp,

    // srio engines
    output bridge_pkg::tx_cmd_t         tx_cmd,
    input  bridge_pkg::tx_status_t      tx_status,
    input  bridge_pkg::rx_event_t       rx_event,
    output logic                        nw_mode,

    // interrupts
    input  logic                        msi_irq_in,
    input  logic [`AXIL_DW-1:0]         msi_info_in,
    output logic                        msi_irq_busy,
    output logic [`USR_IRQ_DW-1:0]      usr_irq_req
);

    bridge_pkg::reg_access_t    access;
    logic [`AXIL_DW-1:0]        ctrl_rdata;
    logic [`AXIL_DW-1:0]        msi_rdata;
    logic                       db_nomsi;

    axil_reg_port u_axil (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .access     (access),
        .ctrl_rdata (ctrl_rdata),
        .msi_rdata  (msi_rdata)
    );

    srio_ctrl_regs u_ctrl (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .access     (access),
        .rdata      (ctrl_rdata),
        .tx_cmd     (tx_cmd),
        .tx_status  (tx_status),
        .rx_event   (rx_event),
        .nw_mode    (nw_mode),
        .db_nomsi   (db_nomsi)
    );

    msi_irq_ctrl u_msi (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .access       (access),
        .rdata        (msi_rdata),
        .db_nomsi     (db_nomsi),
        .rx_event     (rx_event),
        .msi_irq_in   (msi_irq_in),
        .msi_info_in  (msi_info_in),
        .msi_irq_busy (msi_irq_busy),
        .usr_irq_req  (usr_irq_req)
    );

endmodule

/* tb.f */
+incdir+src
src/bridge_pkg.sv
src/axil_reg_port.sv
src/srio_ctrl_regs.sv
src/msi_irq_ctrl.sv
src/srio_pcie_bridge.sv
verification/bridge_tb.sv

/* verification/bridge_tb.sv */
`timescale 1ns/10ps
`include "bridge_params.svh"

module bridge_tb;

    localparam int MAX_CYCLES = 4000;   // about 200 transfers of 4 to 5 cycles with 4x margin

    logic                       aclk;
    logic                       aresetn;
    bridge_pkg::axil_req_t      axil_req;
    bridge_pkg::axil_rsp_t      axil_rsp;
    bridge_pkg::tx_cmd_t        tx_cmd;
    bridge_pkg::tx_status_t     tx_status;
    bridge_pkg::rx_event_t      rx_event;
    logic                       nw_mode;
    logic                       msi_irq_in;
    logic [`AXIL_DW-1:0]        msi_info_in;
    logic                       msi_irq_busy;
    logic [`USR_IRQ_DW-1:0]     usr_irq_req;

    // reference model of the register map
    logic [`AXIL_DW-1:0]        exp_reg [0:31];
    logic [`AXIL_DW-1:0]        exp_rdata;
    bridge_pkg::tx_cmd_t        exp_cmd;
    logic [`USR_IRQ_DW+1:0]     exp_side;
    logic [`USR_IRQ_DW+1:0]     side;
    logic [$bits(bridge_pkg::tx_cmd_t)+`USR_IRQ_DW+6:0] ctrl_outs;
    logic                       in_flight;      // dut may run ahead of the model
    int                         errors;
    int                         reads;
    int                         cycles;
    int                         seed;

    srio_pcie_bridge uut (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .tx_cmd       (tx_cmd),
        .tx_status    (tx_status),
        .rx_event     (rx_event),
        .nw_mode      (nw_mode),
        .msi_irq_in   (msi_irq_in),
        .msi_info_in  (msi_info_in),
        .msi_irq_busy (msi_irq_busy),
        .usr_irq_req  (usr_irq_req)
    );

    initial aclk = 1'b0;
    always #5 aclk = ~aclk;

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
            $display("reads: %0d, errors: %0d", reads, errors + 1);
            $display("Done: errors found");
            $finish;
        end
    end

    //////////////////////////////
    // expected engine side outputs
    always_comb begin
        exp_cmd.db_start       = exp_reg[`REG_SRIO_CSR][0];
        exp_cmd.sw_start       = exp_reg[`REG_SRIO_CSR][1];
        exp_cmd.sw_mode        = exp_reg[`REG_SRIO_MODE][1];
        exp_cmd.sw_size        = exp_reg[`REG_SW_SIZE][`SW_SIZE_W-1:0];
        exp_cmd.sw_dst         = exp_reg[`REG_SW_DST];
        exp_cmd.sw_src         = exp_reg[`REG_SW_SRC];
        exp_cmd.db_info_normal = exp_reg[`REG_DB_TXINFO][15:0];
        exp_cmd.db_info_sw     = exp_reg[`REG_DB_TXINFO][31:16];
        exp_side = {exp_reg[`REG_SRIO_MODE][2], exp_reg[`REG_MSI_CSR][1],
                    exp_reg[`REG_MSI_CSR][`USR_IRQ_DW-1:0]};
    end

    assign side      = {nw_mode, msi_irq_busy, usr_irq_req};
    assign ctrl_outs = {tx_cmd, side, axil_rsp.awready, axil_rsp.wready,
                        axil_rsp.bvalid, axil_rsp.arready, axil_rsp.rvalid};

    //////////////////////////////
    // checks
    reset_chk: assert property (@(posedge aclk) $rose(aresetn) |-> ctrl_outs == '0)
        else begin
            errors++;
            $display("mismatch at %0t: ctrl_outs got %h expected 0", $time, $sampled(ctrl_outs));
        end

    rdata_chk: assert property (@(posedge aclk) disable iff (!aresetn)
        axil_rsp.rvalid && axil_req.rready |-> axil_rsp.rdata == exp_rdata)
        else begin
            errors++;
            $display("mismatch at %0t: rdata got %h expected %h", $time,
                     $sampled(axil_rsp.rdata), $sampled(exp_rdata));
        end

    cmd_chk: assert property (@(posedge aclk) disable iff (!aresetn)
        !in_flight |-> tx_cmd == exp_cmd)
        else begin
            errors++;
            $display("mismatch at %0t: tx_cmd got %h expected %h", $time,
                     $sampled(tx_cmd), $sampled(exp_cmd));
        end

    side_chk: assert property (@(posedge aclk) disable iff (!aresetn)
        !in_flight |-> side == exp_side)
        else begin
            errors++;
            $display("mismatch at %0t: {nw_mode, msi_irq_busy, usr_irq_req} got %h expected %h",
                     $time, $sampled(side), $sampled(exp_side));
        end

    resp_chk: assert property (@(posedge aclk) disable iff (!aresetn)
        axil_rsp.bvalid || axil_rsp.rvalid |-> {axil_rsp.bresp, axil_rsp.rresp} == 4'h0)
        else begin
            errors++;
            $display("mismatch at %0t: {bresp, rresp} got %h expected 0", $time,
                     $sampled({axil_rsp.bresp, axil_rsp.rresp}));
        end

    //////////////////////////////
    // model update rules
    function automatic logic [31:0] byte_merge(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old & ~mask) | (data & mask);
    endfunction

    function automatic void apply_write(input int idx, input logic [31:0] data,
                                        input logic [3:0] strb);
        logic lo_set;
        logic hi_set;
        int   b;
        lo_set = strb[0] && (data[7:2] != 6'h0);
        hi_set = strb[1] && (data[15:8] != 8'h0);
        case (idx)
            `REG_SRIO_CSR: begin
                if (strb[0] && data[1:0] != 2'b00) begin
                    for (b = 0; b < 2; b++) begin
                        if (data[b] && exp_reg[1][b]) exp_reg[1][16+b] = 1'b1;  // start while busy
                        else if (data[b]) exp_reg[1][b] = 1'b1;
                    end
                end else if (strb[2]) begin
                    exp_reg[1][21:16] = exp_reg[1][21:16] & ~data[21:16];
                end
            end
            `REG_SRIO_MODE: if (strb[0]) exp_reg[2] = {29'h0, data[2:0]};
            `REG_SW_SIZE: exp_reg[3] = byte_merge(exp_reg[3], data, strb) & 32'h07ff_ffff;
            `REG_SW_DST, `REG_SW_SRC, `REG_DB_TXINFO: begin
                exp_reg[idx] = byte_merge(exp_reg[idx], data, strb);
            end
            `REG_MSI_CSR: begin
                if (!lo_set && strb[2]) exp_reg[7][23:16] = exp_reg[7][23:16] & ~data[23:16];
                if (!hi_set && strb[3]) exp_reg[7][31:24] = exp_reg[7][31:24] & ~data[31:24];
                for (b = 2; b < 16; b++) begin
                    if (data[b] && ((b < 8) ? lo_set : hi_set)) begin
                        if (exp_reg[7][b]) exp_reg[7][16+b] = 1'b1;
                        else exp_reg[7][b] = 1'b1;
                    end
                end
            end
            default: begin
                if (idx >= `REG_MSI_INFO_FIRST && idx <= `REG_MSI_INFO_LAST)
                    exp_reg[idx] = byte_merge(exp_reg[idx], data, strb);
            end
        endcase
    endfunction

    function automatic void apply_event(input bridge_pkg::tx_status_t st,
                                        input bridge_pkg::rx_event_t ev,
                                        input logic irq, input logic [31:0] info);
        if (st.db_done) exp_reg[1][0] = 1'b0;
        if (st.sw_done) exp_reg[1][1] = 1'b0;
        exp_reg[1][21:18] = exp_reg[1][21:18] | {st.sw_err_dst_unalign, st.sw_err_src_unalign,
                                                 ev.nw_err_unalign, ev.nw_err_cross};
        if (ev.db_irq && !exp_reg[2][0]) begin
            if (exp_reg[7][0]) begin
                exp_reg[7][16] = 1'b1;
            end else begin
                exp_reg[7][0] = 1'b1;
                exp_reg[8]    = {16'h0, ev.db_info};
            end
        end
        if (irq) begin
            exp_reg[7][1] = 1'b1;
            exp_reg[9]    = info;
        end
    endfunction

    //////////////////////////////
    // bus and engine drivers
    task automatic bus_write(input int idx, input logic [31:0] data, input logic [3:0] strb);
        @(posedge aclk);
        in_flight = 1'b1;
        axil_req.awaddr  <= `AXIL_AW'(idx * 4);
        axil_req.awvalid <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= strb;
        axil_req.wvalid  <= 1'b1;
        axil_req.bready  <= 1'b1;
        do @(negedge aclk); while (!axil_rsp.awready);
        @(posedge aclk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        do @(negedge aclk); while (!axil_rsp.bvalid);
        @(posedge aclk);
        axil_req.bready <= 1'b0;
        apply_write(idx, data, strb);
        in_flight = 1'b0;
    endtask

    task automatic bus_read(input int idx);
        @(posedge aclk);
        in_flight = 1'b1;
        exp_rdata = exp_reg[idx];
        axil_req.araddr  <= `AXIL_AW'(idx * 4);
        axil_req.arvalid <= 1'b1;
        axil_req.rready  <= 1'b1;
        do @(negedge aclk); while (!axil_rsp.arready);
        @(posedge aclk);
        axil_req.arvalid <= 1'b0;
        do @(negedge aclk); while (!axil_rsp.rvalid);
        @(posedge aclk);
        axil_req.rready <= 1'b0;
        if (idx == `REG_MSI_INFO_FIRST) exp_reg[7][0] = 1'b0;     // read acknowledges
        if (idx == `REG_MSI_INFO_FIRST + 1) exp_reg[7][1] = 1'b0;
        reads++;
        in_flight = 1'b0;
    endtask

    task automatic pulse_event(input bridge_pkg::tx_status_t st, input bridge_pkg::rx_event_t ev,
                               input logic irq, input logic [31:0] info);
        @(posedge aclk);
        in_flight = 1'b1;
        tx_status   <= st;
        rx_event    <= ev;
        msi_irq_in  <= irq;
        msi_info_in <= info;
        @(posedge aclk);
        tx_status  <= '0;
        rx_event   <= '0;
        msi_irq_in <= 1'b0;
        apply_event(st, ev, irq, info);
        in_flight = 1'b0;
    endtask

    //////////////////////////////
    // stimulus
    initial begin
        bridge_pkg::tx_status_t st;
        bridge_pkg::rx_event_t  ev;
        int unsigned            pick;
        int                     idx;
        int                     i;
        axil_req    = '0;
        tx_status   = '0;
        rx_event    = '0;
        msi_irq_in  = 1'b0;
        msi_info_in = '0;
        aresetn     = 1'b0;
        in_flight   = 1'b0;
        seed        = 32'hc6c19dd5;
        for (i = 0; i < 32; i++) exp_reg[i] = '0;
        exp_reg[`REG_IDENT] = `IDENT_VALUE;
        repeat (10) @(posedge aclk);
        aresetn <= 1'b1;

        bus_read(`REG_IDENT);
        bus_write(30, 32'hffff_ffff, 4'hf);     // unmapped word
        bus_read(30);

        // slots get a full word before the read back
        for (i = 10; i <= 23; i++) bus_write(i, $random(seed), 4'hf);
        for (i = 0; i < 40; i++) begin
            pick = $random(seed);
            idx  = (pick % 19 < 5) ? pick % 19 + 2 : pick % 19 + 5;
            bus_write(idx, $random(seed), 4'($random(seed)));
            bus_read(idx);
        end

        // start, busy and start while busy
        st = '0;
        ev = '0;
        bus_write(`REG_SRIO_CSR, 32'h1, 4'h1);
        bus_write(`REG_SRIO_CSR, 32'h1, 4'h1);
        bus_read(`REG_SRIO_CSR);
        st.db_done = 1'b1;
        pulse_event(st, ev, 1'b0, '0);
        bus_write(`REG_SRIO_CSR, 32'h2, 4'h1);
        bus_write(`REG_SRIO_CSR, 32'h3, 4'h1);
        bus_read(`REG_SRIO_CSR);
        st.sw_done = 1'b1;
        pulse_event(st, ev, 1'b0, '0);
        bus_write(`REG_SRIO_CSR, 32'h0001_0000, 4'h4);
        bus_read(`REG_SRIO_CSR);

        // engine errors stay until written with 1
        st = '0;
        ev.nw_err_cross = 1'b1;
        pulse_event(st, ev, 1'b0, '0);
        ev = '0;
        ev.nw_err_unalign = 1'b1;
        st.sw_err_src_unalign = 1'b1;
        pulse_event(st, ev, 1'b0, '0);
        ev = '0;
        st = '0;
        st.sw_err_dst_unalign = 1'b1;
        pulse_event(st, ev, 1'b0, '0);
        bus_write(`REG_SW_DST, $random(seed), 4'hf);
        bus_write(`REG_SRIO_CSR, 32'h0, 4'h4);
        bus_read(`REG_SRIO_CSR);
        bus_write(`REG_SRIO_CSR, 32'h0006_0000, 4'h4);
        bus_read(`REG_SRIO_CSR);
        bus_write(`REG_SRIO_CSR, 32'h003f_0000, 4'h4);
        bus_read(`REG_SRIO_CSR);

        // doorbell to msi bit 0
        st = '0;
        bus_write(`REG_SRIO_MODE, 32'h0, 4'h1);
        ev.db_irq  = 1'b1;
        ev.db_info = 16'($random(seed));
        pulse_event(st, ev, 1'b0, '0);
        ev.db_info = 16'($random(seed));
        pulse_event(st, ev, 1'b0, '0);          // second doorbell before the read
        bus_read(`REG_MSI_CSR);
        bus_read(`REG_MSI_INFO_FIRST);
        bus_read(`REG_MSI_CSR);
        bus_write(`REG_MSI_CSR, 32'h0001_0000, 4'h4);
        bus_write(`REG_SRIO_MODE, 32'h1, 4'h1); // no msi for doorbells
        pulse_event(st, ev, 1'b0, '0);
        bus_read(`REG_MSI_CSR);
        bus_read(`REG_MSI_INFO_FIRST);

        // user irq and software sets
        ev = '0;
        pulse_event(st, ev, 1'b1, $random(seed));
        bus_read(`REG_MSI_CSR);
        bus_read(`REG_MSI_INFO_FIRST + 1);
        bus_write(`REG_MSI_CSR, 32'h0000_0a04, 4'h3);
        bus_write(`REG_MSI_CSR, 32'h0000_0a04, 4'h3);
        bus_read(`REG_MSI_CSR);
        for (i = 0; i < 8; i++) begin
            bus_write(`REG_MSI_CSR, $random(seed), 4'($random(seed)));
            bus_read(`REG_MSI_CSR);
        end

        repeat (3) @(posedge aclk);
        $display("reads: %0d, errors: %0d", reads, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
